// ==== list.f ====
design/rv_pkg.sv
design/ctl_if.sv
design/instr_ctl.sv
design/imm_gen.sv
design/reg_file.sv
design/alu.sv
design/lsu.sv
design/rv_datapath.sv
design/rv_core.sv
verif/rv_core_properties.sv
verif/tb_rv_core.sv

// ==== Makefile ====
# Verilator build and run of the RV32I core testbench
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_rv_core -Mdir obj_dir -f list.f

run: build
	./obj_dir/Vtb_rv_core | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module tb_rv_core -f list.f

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/tb_rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_rv_core;

    logic        clk = 1'b0;
    logic        reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic [3:0]  dmem_be;
    logic        dmem_we;
    logic        dmem_re;
    logic [31:0] dmem_rdata;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_rd_wen;
    logic [4:0]  retire_rd;
    logic [31:0] retire_rd_data;

    logic [31:0] prog [128];         // program ends at byte address 512
    logic [31:0] data_mem [64];      // 256 byte data window at 0x1000
    logic [31:0] model_mem [64];
    logic [31:0] model_regs [32];
    logic [31:0] exp_pc;

    rv_core dut0 (.*);

    always #2 clk = ~clk;

    assign imem_data  = (imem_addr < 32'd512) ? prog[imem_addr[8:2]] : 32'h0000_0013;
    assign dmem_rdata = data_mem[dmem_addr[7:2]];

    always @(posedge clk) begin
        logic [31:0] merged;
        merged = data_mem[dmem_addr[7:2]];
        for (int k = 0; k < 4; k++) begin
            if (dmem_be[k]) begin
                merged[8 * k +: 8] = dmem_wdata[8 * k +: 8];
            end
        end
        if (dmem_we) begin
            data_mem[dmem_addr[7:2]] <= merged;
        end
    end

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ {addr[15:0], addr[31:16]};
    endfunction

    // keeps the access naturally aligned and inside the window
    function automatic logic [11:0] window_offset(input logic [2:0] width);
        case (width[1:0])
            2'b10:   return {4'h0, 6'($urandom), 2'b00};
            2'b01:   return {4'h0, 7'($urandom), 1'b0};
            default: return {4'h0, 8'($urandom)};
        endcase
    endfunction

    function automatic logic [31:0] make_instr(input int idx, input int kind);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        logic [31:0] off;
        logic [31:0] tgt;
        int          span;
        int          pick;
        rd = 5'($urandom);
        if (rd == 5'd1) begin
            rd = 5'd0;   // x1 holds the data window base for the whole run
        end
        rs1   = 5'($urandom);
        rs2   = 5'($urandom);
        f3    = 3'($urandom);
        imm12 = 12'($urandom);
        span  = (127 - idx > 8) ? 8 : 127 - idx;
        if (span < 1) begin
            span = 1;
        end
        off = 32'(4 * (1 + $urandom % span));   // forward and inside the program
        case (kind)
            0: return {20'($urandom), rd, rv_pkg::op_lui};
            1: return {20'($urandom), rd, rv_pkg::op_auipc};
            2: begin
                if (f3 == 3'b001) begin
                    imm12 = {7'h00, 5'($urandom)};
                end else if (f3 == 3'b101) begin
                    imm12 = {1'b0, 1'($urandom), 5'h00, 5'($urandom)};
                end
                return {imm12, rs1, f3, rd, rv_pkg::op_opimm};
            end
            3: begin
                f7 = 7'h00;
                if ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) begin
                    f7 = 7'h20;
                end
                return {f7, rs2, rs1, f3, rd, rv_pkg::op_op};
            end
            4: begin
                pick = int'($urandom % 6);
                f3   = 3'(pick < 2 ? pick : pick + 2);
                if ($urandom % 4 == 0) begin
                    rs2 = rs1;   // equal operands show up often enough this way
                end
                return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_pkg::op_branch};
            end
            5: return {off[20], off[10:1], off[11], off[19:12], rd, rv_pkg::op_jal};
            6: begin
                tgt   = 32'(4 * idx) + off;
                imm12 = {tgt[11:1], 1'($urandom)};   // an odd target must lose bit 0
                return {imm12, 5'd0, 3'b000, rd, rv_pkg::op_jalr};
            end
            7: begin
                pick = int'($urandom % 5);
                f3   = 3'(pick < 3 ? pick : pick + 1);
                return {window_offset(f3), 5'd1, f3, rd, rv_pkg::op_load};
            end
            8: begin
                f3    = 3'($urandom % 3);
                imm12 = window_offset(f3);
                return {imm12[11:5], rs2, 5'd1, f3, imm12[4:0], rv_pkg::op_store};
            end
            default: return {25'($urandom), 7'b0001011};   // custom-0 is not decoded
        endcase
    endfunction

    task automatic build_program();
        prog[0] = {20'h00001, 5'd1, rv_pkg::op_lui};   // x1 = 0x1000
        for (int k = 1; k < 127; k++) begin
            prog[k] = make_instr(k, int'($urandom % 10));
        end
        prog[127] = make_instr(127, 2);
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
        logic [31:0] sra_val;
        sra_val = $signed(x) >>> y[4:0];
        case (f3)
            3'b000:  return alt ? x - y : x + y;
            3'b001:  return x << y[4:0];
            3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'b011:  return (x < y) ? 32'd1 : 32'd0;
            3'b100:  return x ^ y;
            3'b101:  return alt ? sra_val : x >> y[4:0];
            3'b110:  return x | y;
            default: return x & y;
        endcase
    endfunction

    // executes one instruction on the model state and predicts what retires
    function automatic void ref_step(input logic [31:0] pc, input logic [31:0] ins,
                                     output logic wen, output logic [31:0] val,
                                     output logic [31:0] npc);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] addr;
        logic [31:0] word;
        logic        take;
        rd    = ins[11:7];
        f3    = ins[14:12];
        a     = model_regs[ins[19:15]];
        b     = model_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        wen   = 1'b0;
        val   = 32'd0;
        npc   = pc + 32'd4;
        case (ins[6:0])
            rv_pkg::op_lui: begin
                wen = 1'b1;
                val = {ins[31:12], 12'h000};
            end
            rv_pkg::op_auipc: begin
                wen = 1'b1;
                val = pc + {ins[31:12], 12'h000};
            end
            rv_pkg::op_jal: begin
                wen = 1'b1;
                val = pc + 32'd4;
                npc = pc + imm_j;
            end
            rv_pkg::op_jalr: begin
                wen = 1'b1;
                val = pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            rv_pkg::op_branch: begin
                case (f3)
                    3'b000:  take = (a == b);
                    3'b001:  take = (a != b);
                    3'b100:  take = ($signed(a) < $signed(b));
                    3'b101:  take = ($signed(a) >= $signed(b));
                    3'b110:  take = (a < b);
                    3'b111:  take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) begin
                    npc = pc + imm_b;
                end
            end
            rv_pkg::op_load: begin
                addr = a + imm_i;
                word = model_mem[addr[7:2]] >> (8 * addr[1:0]);
                case (f3)
                    3'b000:  val = {{24{word[7]}}, word[7:0]};
                    3'b001:  val = {{16{word[15]}}, word[15:0]};
                    3'b100:  val = {24'd0, word[7:0]};
                    3'b101:  val = {16'd0, word[15:0]};
                    default: val = word;
                endcase
                wen = 1'b1;
            end
            rv_pkg::op_store: begin
                addr = a + imm_s;
                word = model_mem[addr[7:2]];
                case (f3)
                    3'b000:  word[8 * addr[1:0] +: 8] = b[7:0];
                    3'b001:  word[16 * addr[1] +: 16] = b[15:0];
                    default: word = b;
                endcase
                model_mem[addr[7:2]] = word;
            end
            rv_pkg::op_opimm: begin
                wen = 1'b1;
                val = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
            end
            rv_pkg::op_op: begin
                wen = 1'b1;
                val = alu_ref(f3, ins[30], a, b);
            end
            default: ;
        endcase
        if (rd == 5'd0) begin
            wen = 1'b0;
        end
        if (wen) begin
            model_regs[rd] = val;
        end
    endfunction

    task automatic halt_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "first error ends the run");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        halt_run($sformatf("Error: %s = %h, expected %h at pc %h", name, got, want, exp_pc));
    endtask

    initial begin
        int          cycles;
        logic        exp_wen;
        logic        exp_re;
        logic        exp_we;
        logic [31:0] exp_val;
        logic [31:0] next_pc;
        logic [31:0] ins;
        void'($urandom(45399));
        reset = 1'b1;
        build_program();
        for (int k = 0; k < 32; k++) begin
            model_regs[k] = 32'd0;
        end
        for (int k = 0; k < 64; k++) begin
            data_mem[k]  = fill_word(32'h1000 + 32'(4 * k));
            model_mem[k] = data_mem[k];
        end
        repeat (2) @(posedge clk);
        #0.5;
        reset  = 1'b0;
        exp_pc = 32'd0;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid) begin
            cycles++;
            if (cycles > 4) begin
                halt_run("timeout: retire_valid never rose after reset was released");
            end
            @(negedge clk);
        end
        cycles = 0;
        while (exp_pc != 32'd512) begin
            cycles++;
            if (cycles > 512) begin
                halt_run("timeout: the program never ran past its last instruction");
            end
            assert (retire_valid)
                else halt_run("retire_valid dropped in the middle of the program");
            assert (retire_pc == exp_pc)
                else value_error("retire_pc", retire_pc, exp_pc);
            ins    = prog[exp_pc[8:2]];
            exp_re = (ins[6:0] == rv_pkg::op_load);
            exp_we = (ins[6:0] == rv_pkg::op_store);
            assert (dmem_re == exp_re)
                else value_error("dmem_re", 32'(dmem_re), 32'(exp_re));
            assert (dmem_we == exp_we)
                else value_error("dmem_we", 32'(dmem_we), 32'(exp_we));
            ref_step(exp_pc, ins, exp_wen, exp_val, next_pc);
            assert (retire_rd_wen == exp_wen)
                else value_error("retire_rd_wen", 32'(retire_rd_wen), 32'(exp_wen));
            if (exp_wen) begin
                assert (retire_rd == ins[11:7])
                    else value_error("retire_rd", 32'(retire_rd), 32'(ins[11:7]));
                assert (retire_rd_data == exp_val)
                    else value_error("retire_rd_data", retire_rd_data, exp_val);
            end
            exp_pc = next_pc;
            @(negedge clk);
        end
        // every stored byte lane must match the model once the program is done
        for (int k = 0; k < 64; k++) begin
            assert (data_mem[k] == model_mem[k])
                else value_error($sformatf("data_mem[%0d]", k), data_mem[k], model_mem[k]);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/rv_core_properties.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core_properties (
    input logic                     clk,
    input logic                     reset,
    input logic                     retire_valid,
    input logic                     dmem_we,
    input logic                     dmem_re,
    input logic [rv_pkg::xlen-1:0]  retire_pc
);

    // nothing retires and nothing is stored while the core is held in reset
    property idle_in_reset;
        @(posedge clk) reset |-> (!retire_valid && !dmem_we);
    endproperty

    property single_dmem_access;
        @(posedge clk) !(dmem_we && dmem_re);   // an instruction loads or stores, never both
    endproperty

    property pc_word_aligned;
        @(posedge clk) disable iff (reset) retire_pc[1:0] == 2'b00;
    endproperty

    idle_in_reset_a: assert property (idle_in_reset)
        else $error("retire_valid or dmem_we active during reset");
    single_dmem_access_a: assert property (single_dmem_access)
        else $error("dmem_we and dmem_re high together");
    pc_word_aligned_a: assert property (pc_word_aligned)
        else $error("retire_pc is not word aligned");

endmodule

bind rv_core rv_core_properties u_rv_core_properties (
    .clk          (clk),
    .reset        (reset),
    .retire_valid (retire_valid),
    .dmem_we      (dmem_we),
    .dmem_re      (dmem_re),
    .retire_pc    (retire_pc)
);

`default_nettype wire

// ==== design/rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core (
    input  logic                     clk,
    input  logic                     reset,
    output logic [rv_pkg::xlen-1:0]  imem_addr,
    input  logic [rv_pkg::xlen-1:0]  imem_data,
    output logic [rv_pkg::xlen-1:0]  dmem_addr,
    output logic [rv_pkg::xlen-1:0]  dmem_wdata,
    output logic [3:0]               dmem_be,
    output logic                     dmem_we,
    output logic                     dmem_re,
    input  logic [rv_pkg::xlen-1:0]  dmem_rdata,
    output logic                     retire_valid,
    output logic [rv_pkg::xlen-1:0]  retire_pc,
    output logic                     retire_rd_wen,
    output logic [4:0]               retire_rd,
    output logic [rv_pkg::xlen-1:0]  retire_rd_data
);

    rv_pkg::instr_word_u instr;

    ctl_if ctl_bus ();

    instr_ctl u_instr_ctl (
        .instr (instr),
        .ctl   (ctl_bus.ctl)
    );

    // the datapath fetches, so the decoder sees the word it hands back
    rv_datapath u_rv_datapath (
        .clk            (clk),
        .reset          (reset),
        .ctl            (ctl_bus.dp),
        .instr          (instr),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .dmem_addr      (dmem_addr),
        .dmem_wdata     (dmem_wdata),
        .dmem_be        (dmem_be),
        .dmem_we        (dmem_we),
        .dmem_re        (dmem_re),
        .dmem_rdata     (dmem_rdata),
        .retire_valid   (retire_valid),
        .retire_pc      (retire_pc),
        .retire_rd_wen  (retire_rd_wen),
        .retire_rd      (retire_rd),
        .retire_rd_data (retire_rd_data)
    );

endmodule

`default_nettype wire

// ==== design/rv_datapath.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_datapath (
    input  logic                     clk,
    input  logic                     reset,
    ctl_if.dp                        ctl,
    output rv_pkg::instr_word_u      instr,
    output logic [rv_pkg::xlen-1:0]  imem_addr,
    input  logic [rv_pkg::xlen-1:0]  imem_data,
    output logic [rv_pkg::xlen-1:0]  dmem_addr,
    output logic [rv_pkg::xlen-1:0]  dmem_wdata,
    output logic [3:0]               dmem_be,
    output logic                     dmem_we,
    output logic                     dmem_re,
    input  logic [rv_pkg::xlen-1:0]  dmem_rdata,
    output logic                     retire_valid,
    output logic [rv_pkg::xlen-1:0]  retire_pc,
    output logic                     retire_rd_wen,
    output logic [4:0]               retire_rd,
    output logic [rv_pkg::xlen-1:0]  retire_rd_data
);

    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] pc_plus4;
    logic [rv_pkg::xlen-1:0] next_pc;
    logic [rv_pkg::xlen-1:0] rdata1;
    logic [rv_pkg::xlen-1:0] rdata2;
    logic [rv_pkg::xlen-1:0] imm;
    logic [rv_pkg::xlen-1:0] op_a;
    logic [rv_pkg::xlen-1:0] op_b;
    logic [rv_pkg::xlen-1:0] alu_y;
    logic [rv_pkg::xlen-1:0] load_data;
    logic [rv_pkg::xlen-1:0] wb_data;
    logic                    live;
    logic                    wen;

    assign live = !reset;   // nothing commits while the core is held in reset

    assign instr     = imem_data;
    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;
    assign next_pc   = ctl.pc_sel ? {alu_y[31:1], 1'b0} : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    assign wen = ctl.reg_wen && live;

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs1    (instr.r.rs1),
        .rs2    (instr.r.rs2),
        .rd     (instr.r.rd),
        .wen    (wen),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    imm_gen u_imm_gen (
        .instr   (instr),
        .imm_sel (ctl.imm_sel),
        .imm     (imm)
    );

    // compare flags come from the register reads only, so pc_sel cannot loop back
    assign ctl.br_eq = (rdata1 == rdata2);
    assign ctl.br_lt = ctl.br_un ? (rdata1 < rdata2) : ($signed(rdata1) < $signed(rdata2));

    assign op_a = ctl.a_sel ? pc : rdata1;
    assign op_b = ctl.b_sel ? imm : rdata2;

    alu u_alu (
        .a  (op_a),
        .b  (op_b),
        .op (ctl.alu_sel),
        .y  (alu_y)
    );

    lsu u_lsu (
        .addr       (alu_y),
        .width      (instr.r.funct3),
        .store_data (rdata2),
        .wr         (ctl.mem_wr && live),
        .rd         (ctl.mem_rd && live),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_be    (dmem_be),
        .dmem_we    (dmem_we),
        .dmem_re    (dmem_re),
        .dmem_rdata (dmem_rdata),
        .load_data  (load_data)
    );

    always_comb begin
        case (ctl.wb_sel)
            rv_pkg::wb_mem: wb_data = load_data;
            rv_pkg::wb_pc4: wb_data = pc_plus4;
            rv_pkg::wb_alu: wb_data = alu_y;
            default:        wb_data = alu_y;
        endcase
    end

    assign retire_valid   = live;
    assign retire_pc      = pc;
    assign retire_rd_wen  = wen && (instr.r.rd != 5'd0);
    assign retire_rd      = instr.r.rd;
    assign retire_rd_data = wb_data;

endmodule

`default_nettype wire

// ==== design/lsu.sv ====
`default_nettype none
`timescale 1ns/100ps

module lsu (
    input  logic [rv_pkg::xlen-1:0]  addr,
    input  logic [2:0]               width,
    input  logic [rv_pkg::xlen-1:0]  store_data,
    input  logic                     wr,
    input  logic                     rd,
    output logic [rv_pkg::xlen-1:0]  dmem_addr,
    output logic [rv_pkg::xlen-1:0]  dmem_wdata,
    output logic [3:0]               dmem_be,
    output logic                     dmem_we,
    output logic                     dmem_re,
    input  logic [rv_pkg::xlen-1:0]  dmem_rdata,
    output logic [rv_pkg::xlen-1:0]  load_data
);

    logic [rv_pkg::xlen-1:0] lane;

    assign dmem_addr = {addr[31:2], 2'b00};
    assign dmem_we   = wr;
    assign dmem_re   = rd;

    // store data goes out on every lane and the byte enables pick the right one
    always_comb begin
        case (width)
            rv_pkg::width_b, rv_pkg::width_bu: begin
                dmem_wdata = {4{store_data[7:0]}};
                dmem_be    = 4'b0001 << addr[1:0];
            end
            rv_pkg::width_h, rv_pkg::width_hu: begin
                dmem_wdata = {2{store_data[15:0]}};
                dmem_be    = addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                dmem_wdata = store_data;
                dmem_be    = 4'b1111;
            end
        endcase
    end

    assign lane = dmem_rdata >> {addr[1:0], 3'b000};   // addressed byte moved to bit 0

    always_comb begin
        case (width)
            rv_pkg::width_b:  load_data = {{24{lane[7]}}, lane[7:0]};
            rv_pkg::width_bu: load_data = {24'd0, lane[7:0]};
            rv_pkg::width_h:  load_data = {{16{lane[15]}}, lane[15:0]};
            rv_pkg::width_hu: load_data = {16'd0, lane[15:0]};
            rv_pkg::width_w:  load_data = dmem_rdata;
            default:          load_data = dmem_rdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module alu (
    input  logic [rv_pkg::xlen-1:0]  a,
    input  logic [rv_pkg::xlen-1:0]  b,
    input  logic [3:0]               op,
    output logic [rv_pkg::xlen-1:0]  y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            rv_pkg::alu_add:    y = a + b;
            rv_pkg::alu_sub:    y = a - b;
            rv_pkg::alu_sll:    y = a << shamt;
            rv_pkg::alu_srl:    y = a >> shamt;
            rv_pkg::alu_sra:    y = $signed(a) >>> shamt;
            rv_pkg::alu_slt:    y = {31'd0, $signed(a) < $signed(b)};
            rv_pkg::alu_sltu:   y = {31'd0, a < b};
            rv_pkg::alu_xor:    y = a ^ b;
            rv_pkg::alu_or:     y = a | b;
            rv_pkg::alu_and:    y = a & b;
            rv_pkg::alu_pass_b: y = b;   // lui goes straight through
            default:            y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none
`timescale 1ns/100ps

module reg_file (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic                     wen,
    input  logic [rv_pkg::xlen-1:0]  wdata,
    output logic [rv_pkg::xlen-1:0]  rdata1,
    output logic [rv_pkg::xlen-1:0]  rdata2
);

    logic [rv_pkg::xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (wen && rd != 5'd0) begin
            regs[rd] <= wdata;   // x0 never takes a write
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

`default_nettype wire

// ==== design/imm_gen.sv ====
`default_nettype none
`timescale 1ns/100ps

module imm_gen (
    input  rv_pkg::instr_word_u      instr,
    input  logic [2:0]               imm_sel,
    output logic [rv_pkg::xlen-1:0]  imm
);

    always_comb begin
        case (imm_sel)
            rv_pkg::imm_i: imm = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            rv_pkg::imm_s: imm = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
            rv_pkg::imm_b: begin
                imm = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            rv_pkg::imm_u: imm = {instr.u.imm_31_12, 12'h000};
            rv_pkg::imm_j: begin
                // the J pieces are scattered the most and bit 0 is implied zero
                imm = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/instr_ctl.sv ====
`default_nettype none
`timescale 1ns/100ps

module instr_ctl (
    input  rv_pkg::instr_word_u instr,
    ctl_if.ctl                  ctl
);

    // maps funct3 to an ALU op and alt picks sub or sra where funct7 bit 5 is set
    function automatic logic [3:0] alu_decode(input logic [2:0] f3, input logic alt);
        logic [3:0] op;
        case (f3)
            3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
            3'b001:  op = rv_pkg::alu_sll;
            3'b010:  op = rv_pkg::alu_slt;
            3'b011:  op = rv_pkg::alu_sltu;
            3'b100:  op = rv_pkg::alu_xor;
            3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
            3'b110:  op = rv_pkg::alu_or;
            default: op = rv_pkg::alu_and;
        endcase
        return op;
    endfunction

    logic is_branch;

    assign is_branch = (instr.b.opcode == rv_pkg::op_branch);

    // unsigned compare only for bltu and bgeu
    assign ctl.br_un = is_branch && (instr.b.funct3[2:1] == 2'b11);

    always_comb begin
        ctl.a_sel   = 1'b0;
        ctl.b_sel   = 1'b1;
        ctl.alu_sel = rv_pkg::alu_add;
        ctl.imm_sel = rv_pkg::imm_i;
        ctl.reg_wen = 1'b0;
        ctl.mem_wr  = 1'b0;
        ctl.mem_rd  = 1'b0;
        ctl.wb_sel  = rv_pkg::wb_alu;
        case (instr.r.opcode)
            rv_pkg::op_lui: begin
                ctl.alu_sel = rv_pkg::alu_pass_b;
                ctl.imm_sel = rv_pkg::imm_u;
                ctl.reg_wen = 1'b1;
            end
            rv_pkg::op_auipc: begin
                ctl.a_sel   = 1'b1;
                ctl.imm_sel = rv_pkg::imm_u;
                ctl.reg_wen = 1'b1;
            end
            rv_pkg::op_jal: begin
                ctl.a_sel   = 1'b1;
                ctl.imm_sel = rv_pkg::imm_j;
                ctl.reg_wen = 1'b1;
                ctl.wb_sel  = rv_pkg::wb_pc4;
            end
            rv_pkg::op_jalr: begin
                ctl.reg_wen = 1'b1;   // target is rs1 plus the I immediate
                ctl.wb_sel  = rv_pkg::wb_pc4;
            end
            rv_pkg::op_branch: begin
                ctl.a_sel   = 1'b1;
                ctl.imm_sel = rv_pkg::imm_b;
            end
            rv_pkg::op_load: begin
                ctl.reg_wen = 1'b1;
                ctl.mem_rd  = 1'b1;
                ctl.wb_sel  = rv_pkg::wb_mem;
            end
            rv_pkg::op_store: begin
                ctl.imm_sel = rv_pkg::imm_s;
                ctl.mem_wr  = 1'b1;
            end
            rv_pkg::op_opimm: begin
                // funct7 only matters for the right shifts here
                ctl.alu_sel = alu_decode(instr.i.funct3,
                                         instr.r.funct7[5] && (instr.i.funct3 == 3'b101));
                ctl.reg_wen = 1'b1;
            end
            rv_pkg::op_op: begin
                ctl.b_sel   = 1'b0;
                ctl.alu_sel = alu_decode(instr.r.funct3, instr.r.funct7[5]);
                ctl.reg_wen = 1'b1;
            end
            default: ;   // anything else retires as a no-op
        endcase
    end

    always_comb begin
        ctl.pc_sel = 1'b0;
        if (instr.r.opcode == rv_pkg::op_jal || instr.r.opcode == rv_pkg::op_jalr) begin
            ctl.pc_sel = 1'b1;
        end else if (is_branch) begin
            case (instr.b.funct3)
                rv_pkg::f3_beq:  ctl.pc_sel = ctl.br_eq;
                rv_pkg::f3_bne:  ctl.pc_sel = !ctl.br_eq;
                rv_pkg::f3_blt:  ctl.pc_sel = ctl.br_lt;
                rv_pkg::f3_bge:  ctl.pc_sel = !ctl.br_lt;
                rv_pkg::f3_bltu: ctl.pc_sel = ctl.br_lt;
                rv_pkg::f3_bgeu: ctl.pc_sel = !ctl.br_lt;
                default:         ctl.pc_sel = 1'b0;   // reserved codes fall through
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/ctl_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface ctl_if;

    logic       a_sel;    // 1 takes the PC as operand a
    logic       b_sel;    // 1 takes the immediate as operand b
    logic [3:0] alu_sel;
    logic [2:0] imm_sel;
    logic       reg_wen;
    logic       mem_wr;
    logic       mem_rd;
    logic       br_un;
    logic       pc_sel;   // 1 redirects to the ALU result
    logic [1:0] wb_sel;
    logic       br_eq;
    logic       br_lt;

    modport ctl (
        output a_sel, b_sel, alu_sel, imm_sel, reg_wen, mem_wr, mem_rd, br_un, pc_sel, wb_sel,
        input  br_eq, br_lt
    );

    modport dp (
        input  a_sel, b_sel, alu_sel, imm_sel, reg_wen, mem_wr, mem_rd, br_un, pc_sel, wb_sel,
        output br_eq, br_lt
    );

endinterface

`default_nettype wire

// ==== design/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // major opcodes of the base integer set
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_opimm  = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;

    localparam logic [3:0] alu_add    = 4'd0;
    localparam logic [3:0] alu_sub    = 4'd1;
    localparam logic [3:0] alu_sll    = 4'd2;
    localparam logic [3:0] alu_srl    = 4'd3;
    localparam logic [3:0] alu_sra    = 4'd4;
    localparam logic [3:0] alu_slt    = 4'd5;
    localparam logic [3:0] alu_sltu   = 4'd6;
    localparam logic [3:0] alu_xor    = 4'd7;
    localparam logic [3:0] alu_or     = 4'd8;
    localparam logic [3:0] alu_and    = 4'd9;
    localparam logic [3:0] alu_pass_b = 4'd10;

    localparam logic [2:0] imm_i = 3'd0;
    localparam logic [2:0] imm_s = 3'd1;
    localparam logic [2:0] imm_b = 3'd2;
    localparam logic [2:0] imm_u = 3'd3;
    localparam logic [2:0] imm_j = 3'd4;

    localparam logic [1:0] wb_mem = 2'd0;
    localparam logic [1:0] wb_alu = 2'd1;
    localparam logic [1:0] wb_pc4 = 2'd2;

    // branch conditions as coded in funct3
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // load and store access widths, also funct3
    localparam logic [2:0] width_b  = 3'b000;
    localparam logic [2:0] width_h  = 3'b001;
    localparam logic [2:0] width_w  = 3'b010;
    localparam logic [2:0] width_bu = 3'b100;
    localparam logic [2:0] width_hu = 3'b101;

    // one instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_word_u;

endpackage

`default_nettype wire
